// ==== compile.f ====
+incdir+design
design/mpf_edge_pkg.sv
design/wr_beat_tracker.sv
design/wr_heap_alloc.sv
design/wr_data_store.sv
design/wr_req_forward.sv
design/wr_flow_ctrl.sv
design/mpf_afu_edge.sv
test/mpf_edge_assert.sv
test/tb_mpf_afu_edge.sv

// ==== design/mpf_afu_edge.sv ====
`timescale 1ns/10ps
`default_nettype none

// Accelerator side edge of the write request pipeline
// Beats are stored in the local heap and a single request per packet goes
// downstream with the heap index in place of the data
module mpf_afu_edge
    import mpf_edge_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,

    // ==================================================
    // Accelerator write channel
    // ==================================================
    input  wire logic       wr_valid,
    input  wire logic       wr_sop,
    input  wire t_cl_len    wr_cl_len,
    input  wire t_line_addr wr_addr,
    input  wire t_line_data wr_data,
    output logic            wr_almost_full,

    // ==================================================
    // Downstream request and heap access
    // ==================================================
    output logic            req_valid,
    output t_line_addr      req_addr,
    output t_cl_len         req_cl_len,
    output t_heap_idx       req_heap_idx,
    input  wire logic       fiu_almost_full,

    // Slot return once downstream has read the data
    input  wire logic       free,
    input  wire t_heap_idx  free_idx,

    // Data readback by slot and beat
    input  wire logic       rd_en,
    input  wire t_heap_idx  rd_idx,
    input  wire t_beat_num  rd_beat,
    output t_line_data      rd_data
);

    // Beat with recovered header
    logic       beat_valid;
    t_line_addr beat_addr;
    t_cl_len    beat_cl_len;
    t_beat_num  beat_num;
    t_line_data beat_data;
    logic       pkt_done;
    logic       packet_active;

    // Heap slot state
    t_heap_idx  alloc_idx;
    logic       heap_low;

    wr_beat_tracker tracker
    (
        .clk(clk),
        .reset(reset),
        .wr_valid(wr_valid),
        .wr_sop(wr_sop),
        .wr_cl_len(wr_cl_len),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .beat_valid(beat_valid),
        .beat_addr(beat_addr),
        .beat_cl_len(beat_cl_len),
        .beat_num(beat_num),
        .beat_data(beat_data),
        .pkt_done(pkt_done),
        .packet_active(packet_active)
    );

    wr_heap_alloc heap_alloc
    (
        .clk(clk),
        .reset(reset),
        .pkt_done(pkt_done),
        .free(free),
        .free_idx(free_idx),
        .alloc_idx(alloc_idx),
        .heap_low(heap_low)
    );

    wr_data_store data_store
    (
        .clk(clk),
        .beat_valid(beat_valid),
        .alloc_idx(alloc_idx),
        .beat_num(beat_num),
        .beat_data(beat_data),
        .rd_en(rd_en),
        .rd_idx(rd_idx),
        .rd_beat(rd_beat),
        .rd_data(rd_data)
    );

    wr_req_forward req_forward
    (
        .clk(clk),
        .reset(reset),
        .pkt_done(pkt_done),
        .beat_addr(beat_addr),
        .beat_cl_len(beat_cl_len),
        .alloc_idx(alloc_idx),
        .req_valid(req_valid),
        .req_addr(req_addr),
        .req_cl_len(req_cl_len),
        .req_heap_idx(req_heap_idx)
    );

    // Flow control sits beside the pipeline
    wr_flow_ctrl flow_ctrl
    (
        .clk(clk),
        .reset(reset),
        .fiu_almost_full(fiu_almost_full),
        .heap_low(heap_low),
        .packet_active(packet_active),
        .wr_almost_full(wr_almost_full)
    );

endmodule

`default_nettype wire

// ==== design/mpf_edge_cfg.svh ====
`ifndef MPF_EDGE_CFG_SVH
`define MPF_EDGE_CFG_SVH

// ==================================================
// Write edge sizing
// ==================================================

// Cache-line address width in bits
`define MPF_ADDR_W 32

// Width of one data beat
`define MPF_DATA_W 64

// Number of write heap slots
// Each slot is big enough for a whole packet
`define MPF_HEAP_ENTRIES 16

// Longest multi-beat write packet
`define MPF_MAX_BEATS 4

// The heap is low once the free count drops to this level
`define MPF_HEAP_RESERVE 4

`endif

// ==== design/mpf_edge_pkg.sv ====
`default_nettype none

`include "mpf_edge_cfg.svh"

package mpf_edge_pkg;

    // Slot index into the write heap
    typedef logic [$clog2(`MPF_HEAP_ENTRIES)-1:0] t_heap_idx;

    // Beat number within one packet
    typedef logic [$clog2(`MPF_MAX_BEATS)-1:0] t_beat_num;

    typedef logic [`MPF_ADDR_W-1:0] t_line_addr;
    typedef logic [`MPF_DATA_W-1:0] t_line_data;

    // Packet length, encoded as the number of the last beat
    typedef enum logic [1:0]
    {
        CL_LEN_1 = 2'd0,
        CL_LEN_2 = 2'd1,
        CL_LEN_4 = 2'd3
    } t_cl_len;

    // Beat tracker state
    typedef enum logic
    {
        PKT_IDLE,
        PKT_ACTIVE
    } t_pkt_state;

endpackage

`default_nettype wire

// ==== design/wr_beat_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

// First stage of the write edge
// The accelerator only promises a valid header on the start beat of a
// packet, so the start header is held here and substituted into the
// later beats
module wr_beat_tracker
    import mpf_edge_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,

    // Raw beat from the accelerator
    input  wire logic       wr_valid,
    input  wire logic       wr_sop,
    input  wire t_cl_len    wr_cl_len,
    input  wire t_line_addr wr_addr,
    input  wire t_line_data wr_data,

    // Beat with the start-of-packet header restored
    output logic            beat_valid,
    output t_line_addr      beat_addr,
    output t_cl_len         beat_cl_len,
    output t_beat_num       beat_num,
    output t_line_data      beat_data,
    output logic            pkt_done,
    output logic            packet_active
);

    t_pkt_state state;

    // Number of the next beat expected in the open packet
    t_beat_num beat_cnt;

    // Header saved from the start beat
    t_line_addr sop_addr;
    t_cl_len    sop_cl_len;

    // ==================================================
    // Header recovery
    // ==================================================

    always_comb
    begin
        beat_valid = wr_valid;
        beat_data = wr_data;

        // The start beat carries the real header and later beats may carry junk
        beat_addr = wr_sop ? wr_addr : sop_addr;
        beat_cl_len = wr_sop ? wr_cl_len : sop_cl_len;
        beat_num = wr_sop ? t_beat_num'(0) : beat_cnt;

        // Last beat once the beat number reaches the encoded length
        pkt_done = wr_valid && (beat_num == t_beat_num'(beat_cl_len));
        packet_active = (state == PKT_ACTIVE);
    end

    // Capture the start beat header for the rest of the packet
    always_ff @(posedge clk)
    begin
        if (wr_valid && wr_sop)
        begin
            sop_addr <= wr_addr;
            sop_cl_len <= wr_cl_len;
        end
    end

    // ==================================================
    // Packet state and beat counter
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= PKT_IDLE;
            beat_cnt <= '0;
        end
        else if (wr_valid)
        begin
            if (pkt_done)
            begin
                // The packet is complete and the next beat must be a start beat
                state <= PKT_IDLE;
                beat_cnt <= '0;
            end
            else
            begin
                state <= PKT_ACTIVE;
                beat_cnt <= beat_num + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/wr_data_store.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mpf_edge_cfg.svh"

// Write data heap
// Each slot holds the maximum number of beats, addressed by slot and beat
module wr_data_store
    import mpf_edge_pkg::*;
(
    input  wire logic       clk,

    // Write side from the beat tracker
    input  wire logic       beat_valid,
    input  wire t_heap_idx  alloc_idx,
    input  wire t_beat_num  beat_num,
    input  wire t_line_data beat_data,

    // Read side for the downstream consumer
    input  wire logic       rd_en,
    input  wire t_heap_idx  rd_idx,
    input  wire t_beat_num  rd_beat,
    output t_line_data      rd_data
);

    t_line_data mem [`MPF_HEAP_ENTRIES * `MPF_MAX_BEATS];

    // Every beat lands in the slot at the head of the free list
    always_ff @(posedge clk)
    begin
        if (beat_valid)
        begin
            mem[{alloc_idx, beat_num}] <= beat_data;
        end
    end

    // Read data is registered and follows rd_en by one cycle
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[{rd_idx, rd_beat}];
        end
    end

endmodule

`default_nettype wire

// ==== design/wr_flow_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

// Almost-full toward the accelerator
// Once a packet has started it must be absorbed whole, so the flag is
// not raised inside a packet unless it was already pending at its start
module wr_flow_ctrl
(
    input  wire logic clk,
    input  wire logic reset,

    input  wire logic fiu_almost_full,
    input  wire logic heap_low,
    input  wire logic packet_active,

    output logic      wr_almost_full
);

    logic full_cond;
    logic sticky_full;

    // Downstream back-pressure or too few heap slots
    assign full_cond = fiu_almost_full || heap_low;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_almost_full <= 1'b1;
            sticky_full <= 1'b0;
        end
        else
        begin
            wr_almost_full <= full_cond && (!packet_active || sticky_full);

            // Sticky flag catches a condition seen between packets
            if (!full_cond)
            begin
                sticky_full <= 1'b0;
            end
            else if (!packet_active)
            begin
                sticky_full <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/wr_heap_alloc.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mpf_edge_cfg.svh"

// Free list of write heap slots
// A whole packet lives in one slot, so the head is taken only when the
// last beat of a packet has been stored
module wr_heap_alloc
    import mpf_edge_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,

    // Consume the head slot
    input  wire logic      pkt_done,

    // Return a slot from downstream
    input  wire logic      free,
    input  wire t_heap_idx free_idx,

    output t_heap_idx      alloc_idx,
    output logic           heap_low
);

    // Circular list of free slot indices
    t_heap_idx free_list [`MPF_HEAP_ENTRIES];

    t_heap_idx head;
    t_heap_idx tail;

    // Count needs one extra bit to hold a completely free heap
    logic [$clog2(`MPF_HEAP_ENTRIES):0] free_cnt;

    // The head of the list is the slot for the packet now arriving
    assign alloc_idx = free_list[head];

    // Few enough slots left that a new packet should be held off
    assign heap_low = (free_cnt <= `MPF_HEAP_RESERVE);

    // ==================================================
    // List update
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Refill the list with every slot in ascending order
            for (int i = 0; i < `MPF_HEAP_ENTRIES; i++)
            begin
                free_list[i] <= t_heap_idx'(i);
            end

            head <= '0;
            tail <= '0;
            free_cnt <= `MPF_HEAP_ENTRIES;
        end
        else
        begin
            if (pkt_done)
            begin
                head <= head + 1'b1;
            end

            // Freed slots go to the back and are reissued in free order
            if (free)
            begin
                free_list[tail] <= free_idx;
                tail <= tail + 1'b1;
            end

            // An allocate and a free in one cycle leave the count alone
            if (pkt_done && !free)
            begin
                free_cnt <= free_cnt - 1'b1;
            end
            else if (free && !pkt_done)
            begin
                free_cnt <= free_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/wr_req_forward.sv ====
`timescale 1ns/10ps
`default_nettype none

// Request register toward downstream
// Only the last beat of a packet makes a request, so the data for every
// beat is already in the heap when the request leaves
module wr_req_forward
    import mpf_edge_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,

    input  wire logic       pkt_done,
    input  wire t_line_addr beat_addr,
    input  wire t_cl_len    beat_cl_len,
    input  wire t_heap_idx  alloc_idx,

    output logic            req_valid,
    output t_line_addr      req_addr,
    output t_cl_len         req_cl_len,
    output t_heap_idx       req_heap_idx
);

    // One-cycle strobe per completed packet
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req_valid <= 1'b0;
        end
        else
        begin
            req_valid <= pkt_done;
        end
    end

    // The heap index stands in for the write data downstream
    always_ff @(posedge clk)
    begin
        if (pkt_done)
        begin
            req_addr <= beat_addr;
            req_cl_len <= beat_cl_len;
            req_heap_idx <= alloc_idx;
        end
    end

endmodule

`default_nettype wire

// ==== test/mpf_edge_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

// Protocol checks bound into the write edge top level
module mpf_edge_assert
(
    input wire logic clk,
    input wire logic reset,
    input wire logic wr_valid,
    input wire logic wr_sop,
    input wire logic packet_active,
    input wire logic req_valid,
    input wire logic wr_almost_full
);

    // A request strobe lasts one cycle
    // A second strobe right behind it must come from a new one-beat packet
    req_single: assert property (@(posedge clk) disable iff (reset)
        req_valid |=> !req_valid || $past(wr_valid && wr_sop))
        else $error("req_valid stayed high for a second cycle of one packet");

    // The flag holds off the accelerator through reset and one cycle past it
    af_after_reset: assert property (@(posedge clk)
        reset |=> wr_almost_full)
        else $error("wr_almost_full was low on the cycle after reset");

    // A new packet may only begin once the previous one has finished
    sop_when_idle: assert property (@(posedge clk) disable iff (reset)
        wr_valid && wr_sop |-> !packet_active)
        else $error("Start beat arrived while a packet was still open");

endmodule

bind mpf_afu_edge mpf_edge_assert edge_assert
(
    .clk(clk),
    .reset(reset),
    .wr_valid(wr_valid),
    .wr_sop(wr_sop),
    .packet_active(packet_active),
    .req_valid(req_valid),
    .wr_almost_full(wr_almost_full)
);

`default_nettype wire

// ==== test/mpf_edge_vectors.txt ====
# P start_addr beats junk_addr exp_heap_idx raise_fiu_mid d0 d1 d2 d3 | R slot beat exp_data
# F slot | A fiu_almost_full | W exp_wr_almost_full      (all fields hex)
P 00001000 1 0 0 0 00000000a0a0a0a0 0 0 0
P 00002000 4 deadbeef 1 0 b000000000000000 b100000000000001 b200000000000002 b3ffffffffffffff
P 00003000 2 feedface 2 0 c0c0c0c0c0c0c0c0 c1c1c1c1c1c1c1c1 0 0
R 0 0 00000000a0a0a0a0
R 1 0 b000000000000000
R 1 3 b3ffffffffffffff
R 2 1 c1c1c1c1c1c1c1c1
P 00004000 4 badc0de0 3 1 d0 d1 d2 d3
A 0
W 0
R 3 2 d2
P 00005000 1 0 4 0 e4 0 0 0
P 00005040 2 11111111 5 0 e5 f5 0 0
P 00005080 4 22222222 6 0 e6 f6 16 26
P 000050c0 1 0 7 0 e7 0 0 0
P 00005100 2 44444444 8 0 e8 f8 0 0
P 00005140 4 55555555 9 0 e9 f9 19 29
P 00005180 1 0 a 0 ea 0 0 0
P 000051c0 2 66666666 b 0 eb fb 0 0
W 1
F 2
F 0
F 5
F 7
F 9
W 0
P 00006000 2 77777777 c 0 5c 6c 0 0
P 00006040 1 0 d 0 5d 0 0 0
P 00006080 4 88888888 e 0 5e 6e 7e 8e
P 000060c0 1 0 f 0 5f 0 0 0
P 00006100 4 99999999 2 0 52 62 72 82
W 1
F 1
W 0
P 00006200 2 aaaaaaaa 0 0 50 60 0 0
R 0 1 60
R 2 3 82
R e 2 7e
W 1

// ==== test/tb_mpf_afu_edge.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mpf_afu_edge
    import mpf_edge_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 1;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLES_PER_CMD = 20;
    localparam int ARGS = 9;
    localparam logic [31:0] SEED = 32'h5189_3c06;

    logic clk;
    logic reset;
    logic wr_valid;
    logic wr_sop;
    t_cl_len wr_cl_len;
    t_line_addr wr_addr;
    t_line_data wr_data;
    logic wr_almost_full;
    logic req_valid;
    t_line_addr req_addr;
    t_cl_len req_cl_len;
    t_heap_idx req_heap_idx;
    logic fiu_almost_full;
    logic free;
    t_heap_idx free_idx;
    logic rd_en;
    t_heap_idx rd_idx;
    t_beat_num rd_beat;
    t_line_data rd_data;

    // Command letters and their fixed-size argument records from the vector file
    byte cmd_op [$];
    logic [63:0] cmd_arg [$];
    int checks;
    int errors;
    int limit_cycles;

    mpf_afu_edge dut0
    (
        .clk(clk),
        .reset(reset),
        .wr_valid(wr_valid),
        .wr_sop(wr_sop),
        .wr_cl_len(wr_cl_len),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .wr_almost_full(wr_almost_full),
        .req_valid(req_valid),
        .req_addr(req_addr),
        .req_cl_len(req_cl_len),
        .req_heap_idx(req_heap_idx),
        .fiu_almost_full(fiu_almost_full),
        .free(free),
        .free_idx(free_idx),
        .rd_en(rd_en),
        .rd_idx(rd_idx),
        .rd_beat(rd_beat),
        .rd_data(rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // Helpers
    // ==================================================

    // Step to just past the next rising edge
    // Registered outputs are settled here and new inputs are driven here
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic expect_eq(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Length code is the number of the last beat
    function automatic t_cl_len len_from_beats(input int beats);
        t_cl_len len;
        case (beats)
            1: len = CL_LEN_1;
            2: len = CL_LEN_2;
            default: len = CL_LEN_4;
        endcase
        return len;
    endfunction

    task automatic load_vectors();
        int fd;
        int n;
        string line;
        byte op;
        logic [63:0] a [ARGS];
        fd = $fopen("test/mpf_edge_vectors.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("Error: the vector file could not be opened");
            return;
        end
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            // Skip blank lines and the column description
            if (n > 1 && line[0] != "#")
            begin
                foreach (a[k])
                    a[k] = '0;
                n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h", op,
                            a[0], a[1], a[2], a[3], a[4], a[5], a[6], a[7], a[8]);
                cmd_op.push_back(op);
                foreach (a[k])
                    cmd_arg.push_back(a[k]);
            end
        end
        $fclose(fd);
    endtask

    // ==================================================
    // Vector commands
    // ==================================================

    // One packet with random gaps, junk headers on later beats, and
    // optionally downstream back-pressure raised after the first beat
    task automatic send_packet(input int base);
        int beats;
        int gap;
        t_cl_len len;
        beats = int'(cmd_arg[base + 1]);
        len = len_from_beats(beats);
        checks++;
        if (wr_almost_full)
        begin
            errors++;
            $display("Error at %0t ns: packet due to start while wr_almost_full is high", $time);
        end
        for (int i = 0; i < beats; i++)
        begin
            wr_valid = 1'b1;
            wr_sop = (i == 0);
            wr_addr = (i == 0) ? t_line_addr'(cmd_arg[base]) : t_line_addr'(cmd_arg[base + 2]);
            wr_cl_len = (i == 0) ? len : t_cl_len'(~len);
            wr_data = cmd_arg[base + 5 + i];
            next_cycle();
            wr_valid = 1'b0;
            wr_sop = 1'b0;

            // The request appears right after the edge that took the last beat
            expect_eq("req_valid", req_valid, (i == beats - 1));
            expect_eq("wr_almost_full", wr_almost_full, 0);
            if (i == beats - 1)
            begin
                expect_eq("req_addr", req_addr, cmd_arg[base]);
                expect_eq("req_cl_len", req_cl_len, len);
                expect_eq("req_heap_idx", req_heap_idx, cmd_arg[base + 3]);
            end
            else
            begin
                if (cmd_arg[base + 4] != 0)
                    fiu_almost_full = 1'b1;
                gap = $urandom % 3;
                repeat (gap)
                begin
                    next_cycle();
                    expect_eq("req_valid", req_valid, 0);
                    expect_eq("wr_almost_full", wr_almost_full, 0);
                end
            end
        end

        // Strobe ends, and a deferred almost-full shows up now
        next_cycle();
        expect_eq("req_valid", req_valid, 0);
        if (cmd_arg[base + 4] != 0)
            expect_eq("wr_almost_full", wr_almost_full, 1);
    endtask

    task automatic read_beat(input int base);
        rd_en = 1'b1;
        rd_idx = t_heap_idx'(cmd_arg[base]);
        rd_beat = t_beat_num'(cmd_arg[base + 1]);
        next_cycle();
        rd_en = 1'b0;
        expect_eq("rd_data", rd_data, cmd_arg[base + 2]);
    endtask

    task automatic free_slot(input int base);
        free = 1'b1;
        free_idx = t_heap_idx'(cmd_arg[base]);
        next_cycle();
        free = 1'b0;
    endtask

    // Flag changes need one cycle for the count and one for the register
    task automatic check_almost_full(input int base);
        next_cycle();
        next_cycle();
        expect_eq("wr_almost_full", wr_almost_full, cmd_arg[base]);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial
    begin
        checks = 0;
        errors = 0;
        limit_cycles = 0;
        void'($urandom(SEED));
        reset = 1'b1;
        wr_valid = 1'b0;
        wr_sop = 1'b0;
        wr_cl_len = CL_LEN_1;
        wr_addr = '0;
        wr_data = '0;
        fiu_almost_full = 1'b0;
        free = 1'b0;
        free_idx = '0;
        rd_en = 1'b0;
        rd_idx = '0;
        rd_beat = '0;

        load_vectors();
        limit_cycles = RESET_CYCLES + CYCLES_PER_CMD * (cmd_op.size() + 1);

        repeat (RESET_CYCLES)
            next_cycle();
        expect_eq("wr_almost_full", wr_almost_full, 1);
        expect_eq("req_valid", req_valid, 0);
        reset = 1'b0;
        next_cycle();
        expect_eq("wr_almost_full", wr_almost_full, 0);

        for (int c = 0; c < cmd_op.size(); c++)
        begin
            case (cmd_op[c])
                "P": send_packet(c * ARGS);
                "R": read_beat(c * ARGS);
                "F": free_slot(c * ARGS);
                "A":
                begin
                    fiu_almost_full = cmd_arg[c * ARGS][0];
                    next_cycle();
                    next_cycle();
                end
                "W": check_almost_full(c * ARGS);
                default:
                begin
                    errors++;
                    $display("Error: vector command %0d has an unknown letter", c);
                end
            endcase
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // Watchdog sized from the number of vector commands
    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Error: run did not finish within %0d cycles", limit_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
